/* compile.f */
+incdir+src
src/mem_shim_pkg.sv
src/rd_rsp_sort.sv
src/wr_order_guard.sv
src/req_issue.sv
src/mem_shim_top.sv
sim/mem_shim_assert.sv
sim/mem_shim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_shim_tb -f compile.f -o mem_shim_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/mem_shim_sim)"
echo "$sim_out"
grep -qx "TEST OK" <<< "$sim_out" && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

/* sim/mem_shim_assert.sv */
`timescale 1ns/1ps

module mem_shim_assert
(
    input logic                       clk,
    input logic                       rst,
    input logic                       fiu_req_valid,
    input logic                       afu_rd_rsp_valid,
    input logic                       afu_req_full,
    input logic                       fiu_rd_rsp_valid,
    // State of the sorter slot that the current fabric response names
    input mem_shim_pkg::slot_state_t  rsp_slot_state
);

    // Registered valids come out of each reset edge low
    a_rst_quiet: assert property (@(posedge clk)
        rst |=> (!fiu_req_valid && !afu_rd_rsp_valid))
        else $error("Valid output high during reset");

    // A stalled cycle accepts nothing, so no fabric request follows it
    a_no_accept_full: assert property (@(posedge clk) disable iff (rst)
        afu_req_full |=> !fiu_req_valid)
        else $error("Request accepted while afu_req_full is high");

    // A read response only ever lands on a slot that is waiting
    a_rsp_slot_live: assert property (@(posedge clk) disable iff (rst)
        fiu_rd_rsp_valid |-> (rsp_slot_state != mem_shim_pkg::SLOT_FREE))
        else $error("Read response targets a free reorder slot");

endmodule

// The sorter's slot table is reached through its instance in the top level
bind mem_shim_top mem_shim_assert chk
(
    .clk,
    .rst,
    .fiu_req_valid,
    .afu_rd_rsp_valid,
    .afu_req_full,
    .fiu_rd_rsp_valid,
    .rsp_slot_state (rd_sort.slot_state[fiu_rd_rsp_tag])
);

/* sim/mem_shim_tb.sv */
`timescale 1ns/1ps

`include "mem_shim_macros.svh"

module mem_shim_tb;

    localparam int NUM_REQS    = 400;
    localparam int STIM_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int MEM_LINES   = 1 << `MEM_ADDR_W;

    logic                      clk;
    logic                      rst;
    logic                      afu_req_valid;
    mem_shim_pkg::req_kind_t   afu_req_kind;
    logic [`MEM_ADDR_W-1:0]    afu_req_addr;
    logic [`MEM_DATA_W-1:0]    afu_req_data;
    logic [`MEM_MDATA_W-1:0]   afu_req_mdata;
    logic                      afu_req_full;
    logic                      afu_rd_rsp_valid;
    logic [`MEM_DATA_W-1:0]    afu_rd_rsp_data;
    logic [`MEM_MDATA_W-1:0]   afu_rd_rsp_mdata;
    logic                      afu_wr_rsp_valid;
    logic [`MEM_MDATA_W-1:0]   afu_wr_rsp_mdata;
    logic                      fiu_req_valid;
    mem_shim_pkg::req_kind_t   fiu_req_kind;
    logic [`MEM_ADDR_W-1:0]    fiu_req_addr;
    logic [`MEM_DATA_W-1:0]    fiu_req_data;
    logic [`MEM_RD_TAG_W-1:0]  fiu_req_tag;
    logic                      fiu_req_full;
    logic                      fiu_rd_rsp_valid;
    logic [`MEM_RD_TAG_W-1:0]  fiu_rd_rsp_tag;
    logic [`MEM_DATA_W-1:0]    fiu_rd_rsp_data;
    logic                      fiu_wr_rsp_valid;
    logic [`MEM_RD_TAG_W-1:0]  fiu_wr_rsp_tag;

    // LFSR state and the counters for the report
    logic [15:0]               lfsr_state;
    int                        errors;
    int                        checks;
    int                        n_rd;
    int                        n_wr;
    int                        n_full_stall;

    // Reference model that is updated at acceptance
    logic [`MEM_DATA_W-1:0]    ref_mem [MEM_LINES];
    mem_shim_pkg::req_kind_t   acc_kind [$];
    logic [`MEM_ADDR_W-1:0]    acc_addr [$];
    logic [`MEM_MDATA_W-1:0]   acc_mdata [$];
    logic [`MEM_MDATA_W-1:0]   exp_rd_mdata [$];
    logic [`MEM_DATA_W-1:0]    exp_rd_data [$];
    logic [`MEM_MDATA_W-1:0]   exp_wr_mdata [$];
    int                        open_wr;

    // Fabric model with its own memory, which changes when a request reaches it
    logic [`MEM_DATA_W-1:0]    fab_mem [MEM_LINES];
    mem_shim_pkg::req_kind_t   pend_kind [$];
    logic [`MEM_RD_TAG_W-1:0]  pend_tag [$];
    logic [`MEM_DATA_W-1:0]    pend_data [$];
    logic [`MEM_WR_SLOTS-1:0]  wr_tag_open;
    logic [`MEM_ADDR_W-1:0]    wr_tag_addr [`MEM_WR_SLOTS];
    logic [`MEM_MDATA_W-1:0]   wr_tag_mdata [`MEM_WR_SLOTS];

    // AFU side stimulus state
    logic                      req_held;
    int                        full_left;
    logic [`MEM_MDATA_W-1:0]   next_mdata;

    mem_shim_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Random numbers and memory fill
    // ==================================================

    // Right-shifting Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Every address bit changes the line contents
    function automatic logic [`MEM_DATA_W-1:0] fill_line(input int addr);
        return 32'h5A00_0000 ^ (32'(addr) * 32'h0102_0409);
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic check_idle_flag(input string name, input logic act);
        checks++;
        if (act !== 1'b0)
        begin
            errors++;
            $display("ERR t=%0t %s exp=0 got=%b", $time, name, act);
        end
    endtask

    task automatic check_req_full(input logic exp_full);
        checks++;
        if (afu_req_full !== exp_full)
        begin
            errors++;
            $display("ERR t=%0t afu_req_full exp=%b got=%b", $time, exp_full, afu_req_full);
        end
    endtask

    task automatic check_rd_rsp(input logic [`MEM_MDATA_W-1:0] exp_mdata,
                                input logic [`MEM_DATA_W-1:0] exp_data);
        checks++;
        if (afu_rd_rsp_mdata !== exp_mdata)
        begin
            errors++;
            $display("ERR t=%0t afu_rd_rsp_mdata exp=%h got=%h", $time, exp_mdata,
                     afu_rd_rsp_mdata);
        end
        if (afu_rd_rsp_data !== exp_data)
        begin
            errors++;
            $display("ERR t=%0t afu_rd_rsp_data exp=%h got=%h", $time, exp_data,
                     afu_rd_rsp_data);
        end
    endtask

    task automatic check_wr_rsp(input logic [`MEM_MDATA_W-1:0] exp_mdata);
        checks++;
        if (afu_wr_rsp_mdata !== exp_mdata)
        begin
            errors++;
            $display("ERR t=%0t afu_wr_rsp_mdata exp=%h got=%h", $time, exp_mdata,
                     afu_wr_rsp_mdata);
        end
    endtask

    // Issue to the fabric must follow acceptance order
    task automatic check_fiu_req(input mem_shim_pkg::req_kind_t exp_kind,
                                 input logic [`MEM_ADDR_W-1:0] exp_addr);
        checks++;
        if (fiu_req_kind !== exp_kind)
        begin
            errors++;
            $display("ERR t=%0t fiu_req_kind exp=%0d got=%0d", $time, exp_kind, fiu_req_kind);
        end
        if (fiu_req_addr !== exp_addr)
        begin
            errors++;
            $display("ERR t=%0t fiu_req_addr exp=%h got=%h", $time, exp_addr, fiu_req_addr);
        end
    endtask

    // ==================================================
    // Per-cycle models
    // ==================================================

    // Outputs settled at the last rising edge and are read here
    task automatic observe_outputs();
        logic [`MEM_WR_TAG_W-1:0] wt;
        wt = fiu_req_tag[`MEM_WR_TAG_W-1:0];
        if (fiu_req_valid && acc_kind.size() == 0)
        begin
            errors++;
            $display("Fabric request at %0t has no accepted request behind it", $time);
        end
        else if (fiu_req_valid)
        begin
            check_fiu_req(acc_kind[0], acc_addr[0]);
            // A line with a write still at the fabric must not be touched again
            for (int i = 0; i < `MEM_WR_SLOTS; i++)
            begin
                if (wr_tag_open[i] && wr_tag_addr[i] == fiu_req_addr)
                begin
                    errors++;
                    $display("Request to line %h at %0t while a write to it is in flight",
                             fiu_req_addr, $time);
                end
            end
            pend_kind.push_back(fiu_req_kind);
            pend_tag.push_back(fiu_req_tag);
            pend_data.push_back(fab_mem[fiu_req_addr]);
            if (fiu_req_kind == mem_shim_pkg::REQ_WR)
            begin
                fab_mem[fiu_req_addr] = fiu_req_data;
                wr_tag_open[wt]  = 1'b1;
                wr_tag_addr[wt]  = fiu_req_addr;
                wr_tag_mdata[wt] = acc_mdata[0];
            end
            acc_kind.delete(0);
            acc_addr.delete(0);
            acc_mdata.delete(0);
        end
        if (afu_rd_rsp_valid && exp_rd_mdata.size() == 0)
        begin
            errors++;
            $display("Read response at %0t with no read outstanding", $time);
        end
        else if (afu_rd_rsp_valid)
        begin
            check_rd_rsp(exp_rd_mdata.pop_front(), exp_rd_data.pop_front());
        end
        // A write completion is due exactly one cycle after the fabric sent it
        if (exp_wr_mdata.size() != 0)
        begin
            if (!afu_wr_rsp_valid)
            begin
                errors++;
                $display("Write response missing at %0t after a fabric completion", $time);
            end
            else
            begin
                check_wr_rsp(exp_wr_mdata[0]);
            end
            exp_wr_mdata.delete(0);
            open_wr--;
        end
        else if (afu_wr_rsp_valid)
        begin
            errors++;
            $display("Write response at %0t with no write completed by the fabric", $time);
        end
    endtask

    // Most cycles return one pending response, picked at random
    task automatic drive_fabric();
        int idx;
        fiu_rd_rsp_valid = 1'b0;
        fiu_wr_rsp_valid = 1'b0;
        if (pend_kind.size() > 0 && rand_bits(2) != 0)
        begin
            idx = int'(rand_bits(4) % pend_kind.size());
            if (pend_kind[idx] == mem_shim_pkg::REQ_RD)
            begin
                fiu_rd_rsp_valid = 1'b1;
                fiu_rd_rsp_tag   = pend_tag[idx];
                fiu_rd_rsp_data  = pend_data[idx];
            end
            else
            begin
                fiu_wr_rsp_valid = 1'b1;
                fiu_wr_rsp_tag   = pend_tag[idx];
                wr_tag_open[pend_tag[idx][`MEM_WR_TAG_W-1:0]] = 1'b0;
                exp_wr_mdata.push_back(wr_tag_mdata[pend_tag[idx][`MEM_WR_TAG_W-1:0]]);
            end
            pend_kind.delete(idx);
            pend_tag.delete(idx);
            pend_data.delete(idx);
        end
    endtask

    // A stalled request is held unchanged until it is taken
    task automatic drive_afu(input bit gen);
        if (full_left == 0 && rand_bits(4) == 0)
        begin
            full_left = 1 + int'(rand_bits(3));
        end
        fiu_req_full = gen && (full_left > 0);
        if (full_left > 0)
        begin
            full_left--;
        end
        if (!gen)
        begin
            afu_req_valid = 1'b0;
            req_held      = 1'b0;
        end
        else if (!req_held)
        begin
            afu_req_valid = (rand_bits(2) != 0);
            afu_req_kind  = rand_bits(1) == 1 ? mem_shim_pkg::REQ_WR : mem_shim_pkg::REQ_RD;
            afu_req_addr  = `MEM_ADDR_W'(rand_bits(`MEM_ADDR_W));
            afu_req_data  = rand_bits(`MEM_DATA_W);
            afu_req_mdata = next_mdata;
            req_held      = afu_req_valid;
        end
    endtask

    // The shim stalls for a full fabric, a missing slot of the presented kind
    // or a line whose write has not completed yet
    function automatic logic expected_full();
        logic hazard;
        logic no_slot;
        hazard = 1'b0;
        // A write answered this cycle still holds its line until the coming edge
        for (int i = 0; i < `MEM_WR_SLOTS; i++)
        begin
            if ((wr_tag_open[i] || (fiu_wr_rsp_valid && fiu_wr_rsp_tag == i))
                && wr_tag_addr[i] == afu_req_addr)
            begin
                hazard = 1'b1;
            end
        end
        if (afu_req_kind == mem_shim_pkg::REQ_RD)
        begin
            no_slot = (exp_rd_mdata.size() == `MEM_RD_SLOTS);
        end
        else
        begin
            no_slot = (open_wr == `MEM_WR_SLOTS);
        end
        return fiu_req_full || no_slot || hazard;
    endfunction

    // Full has settled, so the coming rising edge is known to accept or not
    task automatic note_accept();
        #1;
        check_req_full(expected_full());
        if (afu_req_valid && fiu_req_full)
        begin
            n_full_stall++;
        end
        if (afu_req_valid && !afu_req_full)
        begin
            acc_kind.push_back(afu_req_kind);
            acc_addr.push_back(afu_req_addr);
            acc_mdata.push_back(afu_req_mdata);
            if (afu_req_kind == mem_shim_pkg::REQ_RD)
            begin
                exp_rd_mdata.push_back(afu_req_mdata);
                exp_rd_data.push_back(ref_mem[afu_req_addr]);
                n_rd++;
            end
            else
            begin
                ref_mem[afu_req_addr] = afu_req_data;
                open_wr++;
                n_wr++;
            end
            next_mdata++;
            req_held = 1'b0;
        end
    endtask

    task automatic step_cycle(input bit gen);
        @(negedge clk);
        observe_outputs();
        drive_fabric();
        drive_afu(gen);
        note_accept();
    endtask

    function automatic bit drained();
        return acc_kind.size() == 0 && exp_rd_mdata.size() == 0 && pend_kind.size() == 0
               && exp_wr_mdata.size() == 0 && open_wr == 0;
    endfunction

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        int cyc;
        int errs_before;
        afu_req_valid    = 1'b0;
        afu_req_kind     = mem_shim_pkg::REQ_RD;
        afu_req_addr     = '0;
        afu_req_data     = '0;
        afu_req_mdata    = '0;
        fiu_req_full     = 1'b0;
        fiu_rd_rsp_valid = 1'b0;
        fiu_rd_rsp_tag   = '0;
        fiu_rd_rsp_data  = '0;
        fiu_wr_rsp_valid = 1'b0;
        fiu_wr_rsp_tag   = '0;
        lfsr_state       = 16'd29758;
        errors           = 0;
        checks           = 0;
        n_rd             = 0;
        n_wr             = 0;
        n_full_stall     = 0;
        open_wr          = 0;
        wr_tag_open      = '0;
        req_held         = 1'b0;
        full_left        = 0;
        next_mdata       = '0;
        for (int i = 0; i < MEM_LINES; i++)
        begin
            ref_mem[i] = fill_line(i);
            fab_mem[i] = fill_line(i);
        end
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle outputs right after reset, before any request
        errs_before = errors;
        #1;
        check_idle_flag("fiu_req_valid", fiu_req_valid);
        check_idle_flag("afu_rd_rsp_valid", afu_rd_rsp_valid);
        check_idle_flag("afu_wr_rsp_valid", afu_wr_rsp_valid);
        check_idle_flag("afu_req_full", afu_req_full);
        $display("test reset_state done, errors=%0d", errors - errs_before);

        errs_before = errors;
        for (cyc = 0; cyc < STIM_LIMIT && (n_rd + n_wr) < NUM_REQS; cyc++)
        begin
            step_cycle(1'b1);
        end
        if ((n_rd + n_wr) < NUM_REQS)
        begin
            errors++;
            $display("Only %0d requests were accepted in %0d cycles", n_rd + n_wr, cyc);
        end
        $display("test random_traffic done, reads=%0d writes=%0d full_stalls=%0d errors=%0d",
                 n_rd, n_wr, n_full_stall, errors - errs_before);

        // Everything accepted must come back once the stimulus stops
        errs_before = errors;
        for (cyc = 0; cyc < DRAIN_LIMIT && !drained(); cyc++)
        begin
            step_cycle(1'b0);
        end
        if (!drained())
        begin
            errors++;
            $display("Responses still outstanding after %0d drain cycles", DRAIN_LIMIT);
        end
        $display("test drain done, errors=%0d", errors - errs_before);

        $display("checks=%0d errors=%0d reads=%0d writes=%0d", checks, errors, n_rd, n_wr);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/mem_shim_macros.svh */
`ifndef MEM_SHIM_MACROS_SVH
`define MEM_SHIM_MACROS_SVH

// Line address width, kept small so that same-line hazards are common
`define MEM_ADDR_W 6

// Width of one line of data
`define MEM_DATA_W 32

// Tag the AFU attaches to every request and expects back
`define MEM_MDATA_W 8

// Reorder buffer depth and the matching read tag width
`define MEM_RD_SLOTS 8
`define MEM_RD_TAG_W 3

// Number of writes that may be in flight to the fabric at once
`define MEM_WR_SLOTS 4
`define MEM_WR_TAG_W 2

`endif

/* src/mem_shim_pkg.sv */
package mem_shim_pkg;

    // ==================================================
    // Request opcode
    // ==================================================

    // One bit is enough, since the shim only moves single-line
    // reads and writes
    typedef enum logic
    {
        REQ_RD = 1'b0,
        REQ_WR = 1'b1
    } req_kind_t;

    // ==================================================
    // Reorder buffer slot state
    // ==================================================

    // A slot is FREE until a read allocates it, WAITs for the fabric,
    // then holds its data as FULL until it reaches the head
    typedef enum logic [1:0]
    {
        SLOT_FREE = 2'd0,
        SLOT_WAIT = 2'd1,
        SLOT_FULL = 2'd2
    } slot_state_t;

endpackage

/* src/mem_shim_top.sv */
`timescale 1ns/1ps

`include "mem_shim_macros.svh"

module mem_shim_top
(
    input  logic                      clk,
    input  logic                      rst,

    // AFU request channel
    input  logic                      afu_req_valid,
    input  mem_shim_pkg::req_kind_t   afu_req_kind,
    input  logic [`MEM_ADDR_W-1:0]    afu_req_addr,
    input  logic [`MEM_DATA_W-1:0]    afu_req_data,
    input  logic [`MEM_MDATA_W-1:0]   afu_req_mdata,
    output logic                      afu_req_full,

    // AFU response channels
    output logic                      afu_rd_rsp_valid,
    output logic [`MEM_DATA_W-1:0]    afu_rd_rsp_data,
    output logic [`MEM_MDATA_W-1:0]   afu_rd_rsp_mdata,
    output logic                      afu_wr_rsp_valid,
    output logic [`MEM_MDATA_W-1:0]   afu_wr_rsp_mdata,

    // FIU request channel
    output logic                      fiu_req_valid,
    output mem_shim_pkg::req_kind_t   fiu_req_kind,
    output logic [`MEM_ADDR_W-1:0]    fiu_req_addr,
    output logic [`MEM_DATA_W-1:0]    fiu_req_data,
    output logic [`MEM_RD_TAG_W-1:0]  fiu_req_tag,
    input  logic                      fiu_req_full,

    // FIU response channels
    input  logic                      fiu_rd_rsp_valid,
    input  logic [`MEM_RD_TAG_W-1:0]  fiu_rd_rsp_tag,
    input  logic [`MEM_DATA_W-1:0]    fiu_rd_rsp_data,
    input  logic                      fiu_wr_rsp_valid,
    input  logic [`MEM_RD_TAG_W-1:0]  fiu_wr_rsp_tag
);

    // Availability and allocation between the issuer and the two tables
    logic                      rd_slot_free;
    logic [`MEM_RD_TAG_W-1:0]  rd_alloc_tag;
    logic                      rd_alloc;
    logic                      wr_slot_free;
    logic [`MEM_WR_TAG_W-1:0]  wr_alloc_tag;
    logic                      wr_alloc;
    logic                      addr_hazard;

    // ==================================================
    // Read reorder buffer
    // ==================================================

    rd_rsp_sort rd_sort
    (
        .clk,
        .rst,
        .rd_alloc,
        .afu_req_mdata,
        .rd_slot_free,
        .rd_alloc_tag,
        .fiu_rd_rsp_valid,
        .fiu_rd_rsp_tag,
        .fiu_rd_rsp_data,
        .afu_rd_rsp_valid,
        .afu_rd_rsp_data,
        .afu_rd_rsp_mdata
    );

    // Write slots and same-line ordering sit beside the sorter
    wr_order_guard wr_guard
    (
        .clk,
        .rst,
        .wr_alloc,
        .afu_req_addr,
        .afu_req_mdata,
        .wr_slot_free,
        .wr_alloc_tag,
        .addr_hazard,
        .fiu_wr_rsp_valid,
        .fiu_wr_rsp_tag,
        .afu_wr_rsp_valid,
        .afu_wr_rsp_mdata
    );

    // ==================================================
    // Request issue to the fabric
    // ==================================================

    req_issue issue
    (
        .clk,
        .rst,
        .afu_req_valid,
        .afu_req_kind,
        .afu_req_addr,
        .afu_req_data,
        .afu_req_full,
        .rd_slot_free,
        .rd_alloc_tag,
        .wr_slot_free,
        .wr_alloc_tag,
        .addr_hazard,
        .rd_alloc,
        .wr_alloc,
        .fiu_req_full,
        .fiu_req_valid,
        .fiu_req_kind,
        .fiu_req_addr,
        .fiu_req_data,
        .fiu_req_tag
    );

endmodule

/* src/rd_rsp_sort.sv */
`timescale 1ns/1ps

`include "mem_shim_macros.svh"

module rd_rsp_sort
(
    input  logic                      clk,
    input  logic                      rst,

    // Allocation of the tail slot by the request issuer
    input  logic                      rd_alloc,
    input  logic [`MEM_MDATA_W-1:0]   afu_req_mdata,
    output logic                      rd_slot_free,
    output logic [`MEM_RD_TAG_W-1:0]  rd_alloc_tag,

    // Out-of-order responses from the fabric
    input  logic                      fiu_rd_rsp_valid,
    input  logic [`MEM_RD_TAG_W-1:0]  fiu_rd_rsp_tag,
    input  logic [`MEM_DATA_W-1:0]    fiu_rd_rsp_data,

    // In-order responses to the AFU
    output logic                      afu_rd_rsp_valid,
    output logic [`MEM_DATA_W-1:0]    afu_rd_rsp_data,
    output logic [`MEM_MDATA_W-1:0]   afu_rd_rsp_mdata
);

    // Per-slot state, the AFU tag saved at request time and the line
    // returned by the fabric
    mem_shim_pkg::slot_state_t slot_state [`MEM_RD_SLOTS];
    logic [`MEM_MDATA_W-1:0]   slot_mdata [`MEM_RD_SLOTS];
    logic [`MEM_DATA_W-1:0]    slot_data  [`MEM_RD_SLOTS];

    // Tail allocates new reads, head releases them in request order
    logic [`MEM_RD_TAG_W-1:0]  tail;
    logic [`MEM_RD_TAG_W-1:0]  head;

    // The head slot has its data and can leave this cycle
    logic                      head_ready;

    // ==================================================
    // Allocation side
    // ==================================================

    // Slots are handed out strictly in ring order, so only the tail
    // slot matters for availability
    assign rd_slot_free = (slot_state[tail] == mem_shim_pkg::SLOT_FREE);
    assign rd_alloc_tag = tail;

    assign head_ready = (slot_state[head] == mem_shim_pkg::SLOT_FULL);

    // ==================================================
    // Slot state and pointers
    // ==================================================

    // The three updates never touch the same slot in one cycle:
    // allocation hits a FREE slot, a response a WAIT slot and the
    // release a FULL slot
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MEM_RD_SLOTS; i++)
            begin
                slot_state[i] <= mem_shim_pkg::SLOT_FREE;
            end
            tail <= '0;
            head <= '0;
        end
        else
        begin
            if (rd_alloc)
            begin
                slot_state[tail] <= mem_shim_pkg::SLOT_WAIT;
                tail <= tail + 1'b1;
            end

            // A response may target any waiting slot
            if (fiu_rd_rsp_valid)
            begin
                slot_state[fiu_rd_rsp_tag] <= mem_shim_pkg::SLOT_FULL;
            end

            // The slot is freed at the same edge its data moves out
            if (head_ready)
            begin
                slot_state[head] <= mem_shim_pkg::SLOT_FREE;
                head <= head + 1'b1;
            end
        end
    end

    // Payload storage needs no reset, since state guards every read
    always_ff @(posedge clk)
    begin
        if (rd_alloc)
        begin
            slot_mdata[tail] <= afu_req_mdata;
        end
        if (fiu_rd_rsp_valid)
        begin
            slot_data[fiu_rd_rsp_tag] <= fiu_rd_rsp_data;
        end
    end

    // ==================================================
    // Registered release to the AFU
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            afu_rd_rsp_valid <= 1'b0;
        end
        else
        begin
            afu_rd_rsp_valid <= head_ready;
        end
    end

    // Data and tag only change when a response actually leaves
    always_ff @(posedge clk)
    begin
        if (head_ready)
        begin
            afu_rd_rsp_data  <= slot_data[head];
            afu_rd_rsp_mdata <= slot_mdata[head];
        end
    end

endmodule

/* src/req_issue.sv */
`timescale 1ns/1ps

`include "mem_shim_macros.svh"

module req_issue
(
    input  logic                      clk,
    input  logic                      rst,

    // Request presented by the AFU
    input  logic                      afu_req_valid,
    input  mem_shim_pkg::req_kind_t   afu_req_kind,
    input  logic [`MEM_ADDR_W-1:0]    afu_req_addr,
    input  logic [`MEM_DATA_W-1:0]    afu_req_data,
    output logic                      afu_req_full,

    // Availability from the sorter and the write guard
    input  logic                      rd_slot_free,
    input  logic [`MEM_RD_TAG_W-1:0]  rd_alloc_tag,
    input  logic                      wr_slot_free,
    input  logic [`MEM_WR_TAG_W-1:0]  wr_alloc_tag,
    input  logic                      addr_hazard,
    output logic                      rd_alloc,
    output logic                      wr_alloc,

    // Request channel to the fabric
    input  logic                      fiu_req_full,
    output logic                      fiu_req_valid,
    output mem_shim_pkg::req_kind_t   fiu_req_kind,
    output logic [`MEM_ADDR_W-1:0]    fiu_req_addr,
    output logic [`MEM_DATA_W-1:0]    fiu_req_data,
    output logic [`MEM_RD_TAG_W-1:0]  fiu_req_tag
);

    logic                      is_rd;
    logic                      slot_ok;
    logic                      accept;
    logic [`MEM_RD_TAG_W-1:0]  issue_tag;

    // ==================================================
    // Accept decision
    // ==================================================

    assign is_rd = (afu_req_kind == mem_shim_pkg::REQ_RD);

    // Each kind only needs a slot in its own table
    assign slot_ok = is_rd ? rd_slot_free : wr_slot_free;

    // Full follows the presented request even when valid is low,
    // so the AFU sees the stall before it commits
    assign afu_req_full = fiu_req_full | ~slot_ok | addr_hazard;
    assign accept       = afu_req_valid & ~afu_req_full;

    // The matching table claims its slot at the accept edge
    assign rd_alloc = accept & is_rd;
    assign wr_alloc = accept & ~is_rd;

    // Write tags are zero-extended into the shared fabric tag field
    assign issue_tag = is_rd ? rd_alloc_tag
                             : {{(`MEM_RD_TAG_W - `MEM_WR_TAG_W){1'b0}}, wr_alloc_tag};

    // ==================================================
    // Registered fabric request
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fiu_req_valid <= 1'b0;
        end
        else
        begin
            fiu_req_valid <= accept;
        end
    end

    // Payload is only loaded for an accepted request
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            fiu_req_kind <= afu_req_kind;
            fiu_req_addr <= afu_req_addr;
            fiu_req_data <= afu_req_data;
            fiu_req_tag  <= issue_tag;
        end
    end

endmodule

/* src/wr_order_guard.sv */
`timescale 1ns/1ps

`include "mem_shim_macros.svh"

module wr_order_guard
(
    input  logic                      clk,
    input  logic                      rst,

    // Allocation by the request issuer, with the presented request
    input  logic                      wr_alloc,
    input  logic [`MEM_ADDR_W-1:0]    afu_req_addr,
    input  logic [`MEM_MDATA_W-1:0]   afu_req_mdata,
    output logic                      wr_slot_free,
    output logic [`MEM_WR_TAG_W-1:0]  wr_alloc_tag,
    output logic                      addr_hazard,

    // Write completions from the fabric, tag in the shared fabric width
    input  logic                      fiu_wr_rsp_valid,
    input  logic [`MEM_RD_TAG_W-1:0]  fiu_wr_rsp_tag,

    // Write responses to the AFU with mdata restored
    output logic                      afu_wr_rsp_valid,
    output logic [`MEM_MDATA_W-1:0]   afu_wr_rsp_mdata
);

    // One entry per write in flight
    logic [`MEM_WR_SLOTS-1:0]  busy;
    logic [`MEM_ADDR_W-1:0]    slot_addr  [`MEM_WR_SLOTS];
    logic [`MEM_MDATA_W-1:0]   slot_mdata [`MEM_WR_SLOTS];

    // Write tags only use the low bits of the fabric tag field
    logic [`MEM_WR_TAG_W-1:0]  rsp_slot;

    assign rsp_slot     = fiu_wr_rsp_tag[`MEM_WR_TAG_W-1:0];
    assign wr_slot_free = ~&busy;

    // ==================================================
    // Lowest free slot and same-line hazard
    // ==================================================

    // Scanning from the top leaves the lowest free index last
    always_comb
    begin
        wr_alloc_tag = '0;
        for (int i = `MEM_WR_SLOTS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                wr_alloc_tag = i[`MEM_WR_TAG_W-1:0];
            end
        end
    end

    // Any request, read or write, to a line with a write still in
    // flight must wait until that write completes
    always_comb
    begin
        addr_hazard = 1'b0;
        for (int i = 0; i < `MEM_WR_SLOTS; i++)
        begin
            if (busy[i] && (slot_addr[i] == afu_req_addr))
            begin
                addr_hazard = 1'b1;
            end
        end
    end

    // ==================================================
    // Slot table
    // ==================================================

    // Allocation takes a free slot and a response frees a busy one,
    // so both can happen at one edge without conflict
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy             <= '0;
            afu_wr_rsp_valid <= 1'b0;
        end
        else
        begin
            if (wr_alloc)
            begin
                busy[wr_alloc_tag] <= 1'b1;
            end
            if (fiu_wr_rsp_valid)
            begin
                busy[rsp_slot] <= 1'b0;
            end
            afu_wr_rsp_valid <= fiu_wr_rsp_valid;
        end
    end

    // Address, mdata and the outgoing tag are plain payload
    always_ff @(posedge clk)
    begin
        if (wr_alloc)
        begin
            slot_addr[wr_alloc_tag]  <= afu_req_addr;
            slot_mdata[wr_alloc_tag] <= afu_req_mdata;
        end
        if (fiu_wr_rsp_valid)
        begin
            afu_wr_rsp_mdata <= slot_mdata[rsp_slot];
        end
    end

endmodule
